// File: xc_pkg.sv
// ========================================
// xc shared definitions
// sizes, divider constants, frame bytes,
// command opcodes and state encodings.
// ========================================

package xc_pkg;

	// input lines and correlation sizes.
	localparam int num_inputs = 4;
	localparam int max_lag = 3;
	localparam int num_pairs = 6;
	localparam int count_width = 16;

	// totals, then autos line-major with lag 1 to 3, then crosses.
	localparam int num_words = num_inputs + num_inputs * max_lag + num_pairs;
	localparam int word_idx_width = $clog2(num_words);

	// line pairs in frame order.
	localparam int pair_a [num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_b [num_pairs] = '{1, 2, 3, 2, 3, 3};

	// intclk cycles per uart bit.
	localparam int baud_div = 8;
	localparam int baud_cnt_width = $clog2(baud_div);

	localparam logic [7:0] frame_header = 8'ha5;
	localparam logic [7:0] default_div = 8'd4;
	localparam logic [15:0] default_len = 16'd16;

	typedef enum logic [7:0] {
		cmd_set_div = 8'h01,
		cmd_set_len = 8'h02,
		cmd_start = 8'h03,
		cmd_stop = 8'h04
	} cmd_e;

	typedef enum logic [1:0] {
		parse_idle,
		parse_div_byte,
		parse_len_hi,
		parse_len_lo
	} parse_state_e;

	typedef enum logic [2:0] {
		send_idle,
		send_header,
		send_seq,
		send_word_hi,
		send_word_lo
	} send_state_e;

	// shared by the uart receiver and transmitter.
	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_e;

endpackage

// File: xc_counts_if.sv
// ========================================
// xc counts snapshot bus
// one window of counts from the correlator
// to the frame sender.
// ========================================

`timescale 1ns/1ns

interface xc_counts_if;

	logic [xc_pkg::count_width-1:0] totals [xc_pkg::num_inputs];
	logic [xc_pkg::count_width-1:0] autos [xc_pkg::num_inputs * xc_pkg::max_lag];
	logic [xc_pkg::count_width-1:0] crosses [xc_pkg::num_pairs];

	// snap marks a fresh snapshot, busy is high while a frame is on the line.
	logic snap;
	logic busy;

	modport producer (output totals, output autos, output crosses, output snap, input busy);
	modport consumer (input totals, input autos, input crosses, input snap, output busy);

endinterface

// File: xc_tick_gen.sv
// ========================================
// xc tick generator
// programmable sample tick and fixed
// uart bit tick.
// ========================================

`timescale 1ns/1ns

module xc_tick_gen (
	input logic intclk,
	input logic rst,
	input logic run,
	input logic [7:0] sample_div,
	input logic start,
	output logic sample_tick,
	output logic bit_tick
);

	logic [7:0] smp_cnt;
	logic [7:0] div_eff;
	logic [xc_pkg::baud_cnt_width-1:0] baud_cnt;

	// a divider of zero behaves like one.
	assign div_eff = (sample_div == 8'd0) ? 8'd1 : sample_div;

	always_ff @(posedge intclk) begin
		if (rst) begin
			smp_cnt <= '0;
			sample_tick <= 1'b0;
		end else if (start) begin
			smp_cnt <= div_eff - 8'd1;
			sample_tick <= 1'b0;
		end else if (run && smp_cnt == 8'd0) begin
			// the reload picks up a new divider at the tick.
			smp_cnt <= div_eff - 8'd1;
			sample_tick <= 1'b1;
		end else begin
			if (run)
				smp_cnt <= smp_cnt - 8'd1;
			sample_tick <= 1'b0;
		end
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			baud_cnt <= '0;
			bit_tick <= 1'b0;
		end else if (int'(baud_cnt) == xc_pkg::baud_div - 1) begin
			baud_cnt <= '0;
			bit_tick <= 1'b1;
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
			bit_tick <= 1'b0;
		end
	end

endmodule

// File: xc_correlator.sv
// ========================================
// xc correlator array
// line sync, history, saturating totals,
// autos and crosses, window snapshot.
// ========================================

`timescale 1ns/1ns

module xc_correlator (
	input logic intclk,
	input logic rst,
	input logic [xc_pkg::num_inputs-1:0] line_in,
	input logic sample_tick,
	input logic start,
	input logic [15:0] int_len,
	xc_counts_if.producer counts
);

	localparam int num_autos = xc_pkg::num_inputs * xc_pkg::max_lag;

	logic [xc_pkg::num_inputs-1:0] line_meta;
	logic [xc_pkg::num_inputs-1:0] line_now;
	// hist[0] holds the previous sample, hist[k] the sample k+1 ticks back.
	logic [xc_pkg::num_inputs-1:0] hist [xc_pkg::max_lag];

	logic [xc_pkg::count_width-1:0] tot_cnt [xc_pkg::num_inputs];
	logic [xc_pkg::count_width-1:0] auto_cnt [num_autos];
	logic [xc_pkg::count_width-1:0] cross_cnt [xc_pkg::num_pairs];
	logic [xc_pkg::count_width-1:0] tot_nxt [xc_pkg::num_inputs];
	logic [xc_pkg::count_width-1:0] auto_nxt [num_autos];
	logic [xc_pkg::count_width-1:0] cross_nxt [xc_pkg::num_pairs];

	logic [15:0] sample_cnt;
	logic window_last;

	function automatic logic [xc_pkg::count_width-1:0] sat_inc(
		input logic [xc_pkg::count_width-1:0] value,
		input logic hit
	);
		if (hit && value != '1)
			return value + 1'b1;
		return value;
	endfunction

	// the tick that brings the count up to int_len closes the window.
	assign window_last = ({1'b0, sample_cnt} + 17'd1) >= {1'b0, int_len};

	always_ff @(posedge intclk) begin
		line_meta <= line_in;
		line_now <= line_meta;
	end

	always_comb begin
		for (int i = 0; i < xc_pkg::num_inputs; i++) begin
			tot_nxt[i] = sat_inc(tot_cnt[i], line_now[i]);
			for (int k = 0; k < xc_pkg::max_lag; k++)
				auto_nxt[i * xc_pkg::max_lag + k] =
					sat_inc(auto_cnt[i * xc_pkg::max_lag + k], line_now[i] & hist[k][i]);
		end
		for (int p = 0; p < xc_pkg::num_pairs; p++)
			cross_nxt[p] = sat_inc(cross_cnt[p],
				line_now[xc_pkg::pair_a[p]] & line_now[xc_pkg::pair_b[p]]);
	end

	always_ff @(posedge intclk) begin
		if (rst || start) begin
			hist <= '{default: '0};
			tot_cnt <= '{default: '0};
			auto_cnt <= '{default: '0};
			cross_cnt <= '{default: '0};
			sample_cnt <= '0;
		end else if (sample_tick) begin
			hist[0] <= line_now;
			for (int k = 1; k < xc_pkg::max_lag; k++)
				hist[k] <= hist[k-1];
			if (window_last) begin
				tot_cnt <= '{default: '0};
				auto_cnt <= '{default: '0};
				cross_cnt <= '{default: '0};
				sample_cnt <= '0;
			end else begin
				tot_cnt <= tot_nxt;
				auto_cnt <= auto_nxt;
				cross_cnt <= cross_nxt;
				sample_cnt <= sample_cnt + 16'd1;
			end
		end
	end

	// while a frame is still going out the snapshot is dropped.
	always_ff @(posedge intclk) begin
		if (rst)
			counts.snap <= 1'b0;
		else
			counts.snap <= sample_tick && window_last && !start && !counts.busy;
	end

	always_ff @(posedge intclk) begin
		if (sample_tick && window_last && !counts.busy) begin
			counts.totals <= tot_nxt;
			counts.autos <= auto_nxt;
			counts.crosses <= cross_nxt;
		end
	end

endmodule

// File: xc_uart_rx.sv
// ========================================
// xc uart receiver
// 8N1, samples mid-bit, strobes each byte.
// ========================================

`timescale 1ns/1ns

module xc_uart_rx (
	input logic intclk,
	input logic rst,
	input logic rx,
	output logic [7:0] rx_byte,
	output logic rx_valid
);

	logic rx_meta;
	logic rx_sync;
	xc_pkg::uart_state_e state;
	logic [xc_pkg::baud_cnt_width-1:0] phase;
	logic [2:0] bit_cnt;
	logic [7:0] shreg;
	logic bit_end;

	assign bit_end = int'(phase) == xc_pkg::baud_div - 1;

	always_ff @(posedge intclk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= xc_pkg::uart_idle;
			phase <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
				xc_pkg::uart_idle: begin
					phase <= '0;
					if (!rx_sync)
						state <= xc_pkg::uart_start;
				end
				xc_pkg::uart_start: begin
					// half a bit in, the line must still be low.
					if (int'(phase) == xc_pkg::baud_div / 2 - 1) begin
						phase <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? xc_pkg::uart_idle : xc_pkg::uart_data;
					end else begin
						phase <= phase + 1'b1;
					end
				end
				xc_pkg::uart_data: begin
					phase <= phase + 1'b1;
					if (bit_end) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= xc_pkg::uart_stop;
					end
				end
				default: begin
					phase <= phase + 1'b1;
					if (bit_end) begin
						state <= xc_pkg::uart_idle;
						rx_valid <= rx_sync;
					end
				end
			endcase
		end
	end

	// data arrives lsb first.
	always_ff @(posedge intclk) begin
		if (state == xc_pkg::uart_data && bit_end)
			shreg <= {rx_sync, shreg[7:1]};
		if (state == xc_pkg::uart_stop && bit_end && rx_sync)
			rx_byte <= shreg;
	end

endmodule

// File: xc_uart_tx.sv
// ========================================
// xc uart transmitter
// 8N1, one byte per load strobe.
// ========================================

`timescale 1ns/1ns

module xc_uart_tx (
	input logic intclk,
	input logic rst,
	input logic bit_tick,
	input logic [7:0] tx_byte,
	input logic tx_load,
	output logic tx,
	output logic tx_busy
);

	xc_pkg::uart_state_e state;
	logic pending;
	logic [2:0] bit_cnt;
	logic [7:0] data;

	// a loaded byte waits for the next bit tick so the start bit is full length.
	assign tx_busy = pending || (state != xc_pkg::uart_idle);

	always_ff @(posedge intclk) begin
		if (tx_load && !tx_busy)
			data <= tx_byte;
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= xc_pkg::uart_idle;
			pending <= 1'b0;
			bit_cnt <= '0;
			tx <= 1'b1;
		end else begin
			if (tx_load && !tx_busy)
				pending <= 1'b1;
			if (bit_tick) begin
				case (state)
					xc_pkg::uart_idle: begin
						if (pending) begin
							pending <= 1'b0;
							tx <= 1'b0;
							state <= xc_pkg::uart_start;
						end
					end
					xc_pkg::uart_start: begin
						bit_cnt <= '0;
						tx <= data[0];
						state <= xc_pkg::uart_data;
					end
					xc_pkg::uart_data: begin
						if (bit_cnt == 3'd7) begin
							tx <= 1'b1;
							state <= xc_pkg::uart_stop;
						end else begin
							bit_cnt <= bit_cnt + 3'd1;
							tx <= data[bit_cnt + 3'd1];
						end
					end
					default: state <= xc_pkg::uart_idle;
				endcase
			end
		end
	end

endmodule

// File: xc_cmd_parser.sv
// ========================================
// xc command parser
// decodes uart bytes into divider, window
// length and run control.
// ========================================

`timescale 1ns/1ns

module xc_cmd_parser (
	input logic intclk,
	input logic rst,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	output logic [7:0] sample_div,
	output logic [15:0] int_len,
	output logic run,
	output logic start
);

	xc_pkg::parse_state_e state;
	logic [7:0] len_hi_byte;

	always_ff @(posedge intclk) begin
		if (rx_valid && state == xc_pkg::parse_len_hi)
			len_hi_byte <= rx_byte;
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= xc_pkg::parse_idle;
			sample_div <= xc_pkg::default_div;
			int_len <= xc_pkg::default_len;
			run <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (rx_valid) begin
				case (state)
					xc_pkg::parse_idle: begin
						// stray bytes outside a command fall through here.
						case (xc_pkg::cmd_e'(rx_byte))
							xc_pkg::cmd_set_div: state <= xc_pkg::parse_div_byte;
							xc_pkg::cmd_set_len: state <= xc_pkg::parse_len_hi;
							xc_pkg::cmd_start: begin
								run <= 1'b1;
								start <= 1'b1;
							end
							xc_pkg::cmd_stop: run <= 1'b0;
							default: state <= xc_pkg::parse_idle;
						endcase
					end
					xc_pkg::parse_div_byte: begin
						sample_div <= rx_byte;
						state <= xc_pkg::parse_idle;
					end
					xc_pkg::parse_len_hi: state <= xc_pkg::parse_len_lo;
					default: begin
						int_len <= {len_hi_byte, rx_byte};
						state <= xc_pkg::parse_idle;
					end
				endcase
			end
		end
	end

endmodule

// File: xc_frame_sender.sv
// ========================================
// xc frame sender
// header, sequence and count words of one
// snapshot, msb first, through the uart.
// ========================================

`timescale 1ns/1ns

module xc_frame_sender (
	input logic intclk,
	input logic rst,
	xc_counts_if.consumer counts,
	output logic [7:0] tx_byte,
	output logic tx_load,
	input logic tx_busy
);

	localparam int auto_base = xc_pkg::num_inputs;
	localparam int cross_base = xc_pkg::num_inputs * (1 + xc_pkg::max_lag);

	logic [xc_pkg::count_width-1:0] words [xc_pkg::num_words];
	xc_pkg::send_state_e state;
	logic [xc_pkg::word_idx_width-1:0] word_idx;
	logic [7:0] seq;
	logic need_load;
	logic tx_busy_q;
	logic tx_done;

	assign counts.busy = (state != xc_pkg::send_idle);
	assign tx_done = tx_busy_q && !tx_busy;

	always_ff @(posedge intclk) begin
		if (counts.snap && state == xc_pkg::send_idle) begin
			for (int i = 0; i < xc_pkg::num_inputs; i++)
				words[i] <= counts.totals[i];
			for (int i = 0; i < xc_pkg::num_inputs * xc_pkg::max_lag; i++)
				words[auto_base + i] <= counts.autos[i];
			for (int p = 0; p < xc_pkg::num_pairs; p++)
				words[cross_base + p] <= counts.crosses[p];
		end
	end

	// the state holds still while tx_load is high, so the byte is stable.
	always_comb begin
		case (state)
			xc_pkg::send_seq: tx_byte = seq;
			xc_pkg::send_word_hi: tx_byte = words[word_idx][15:8];
			xc_pkg::send_word_lo: tx_byte = words[word_idx][7:0];
			default: tx_byte = xc_pkg::frame_header;
		endcase
	end

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= xc_pkg::send_idle;
			word_idx <= '0;
			seq <= '0;
			need_load <= 1'b0;
			tx_load <= 1'b0;
			tx_busy_q <= 1'b0;
		end else begin
			tx_busy_q <= tx_busy;
			tx_load <= 1'b0;
			if (state == xc_pkg::send_idle) begin
				if (counts.snap) begin
					state <= xc_pkg::send_header;
					word_idx <= '0;
					need_load <= 1'b1;
				end
			end else if (need_load) begin
				tx_load <= 1'b1;
				need_load <= 1'b0;
			end else if (tx_done) begin
				need_load <= 1'b1;
				case (state)
					xc_pkg::send_header: state <= xc_pkg::send_seq;
					xc_pkg::send_seq: state <= xc_pkg::send_word_hi;
					xc_pkg::send_word_hi: state <= xc_pkg::send_word_lo;
					default: begin
						if (int'(word_idx) == xc_pkg::num_words - 1) begin
							state <= xc_pkg::send_idle;
							need_load <= 1'b0;
							seq <= seq + 8'd1;
						end else begin
							word_idx <= word_idx + 1'b1;
							state <= xc_pkg::send_word_hi;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: xc_top.sv
// ========================================
// xc top level
// pulse correlator with uart command and
// frame output.
// ========================================

`timescale 1ns/1ns

module xc_top (
	input logic intclk,
	input logic rst,
	input logic [xc_pkg::num_inputs-1:0] line_in,
	input logic rx,
	output logic tx
);

	logic [7:0] sample_div;
	logic [15:0] int_len;
	logic run;
	logic start;
	logic sample_tick;
	logic bit_tick;
	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] tx_byte;
	logic tx_load;
	logic tx_busy;

	xc_counts_if counts ();

	xc_tick_gen u_tick_gen (
		.intclk (intclk),
		.rst (rst),
		.run (run),
		.sample_div (sample_div),
		.start (start),
		.sample_tick (sample_tick),
		.bit_tick (bit_tick)
	);

	xc_uart_rx u_uart_rx (
		.intclk (intclk),
		.rst (rst),
		.rx (rx),
		.rx_byte (rx_byte),
		.rx_valid (rx_valid)
	);

	xc_cmd_parser u_cmd_parser (
		.intclk (intclk),
		.rst (rst),
		.rx_byte (rx_byte),
		.rx_valid (rx_valid),
		.sample_div (sample_div),
		.int_len (int_len),
		.run (run),
		.start (start)
	);

	xc_correlator u_correlator (
		.intclk (intclk),
		.rst (rst),
		.line_in (line_in),
		.sample_tick (sample_tick),
		.start (start),
		.int_len (int_len),
		.counts (counts.producer)
	);

	xc_frame_sender u_frame_sender (
		.intclk (intclk),
		.rst (rst),
		.counts (counts.consumer),
		.tx_byte (tx_byte),
		.tx_load (tx_load),
		.tx_busy (tx_busy)
	);

	xc_uart_tx u_uart_tx (
		.intclk (intclk),
		.rst (rst),
		.bit_tick (bit_tick),
		.tx_byte (tx_byte),
		.tx_load (tx_load),
		.tx (tx),
		.tx_busy (tx_busy)
	);

endmodule

// File: tb_xc_top.sv
// ========================================
// xc top level testbench
// directed tests with a uart driver, a
// frame receiver and a count model.
// ========================================

`timescale 1ns/1ns

module tb_xc_top;

	localparam int frame_len = 2 + 2 * xc_pkg::num_words;
	localparam int bit_cycles = xc_pkg::baud_div;
	localparam int auto_base = xc_pkg::num_inputs;
	localparam int cross_base = xc_pkg::num_inputs * (1 + xc_pkg::max_lag);
	localparam int pair_lo [xc_pkg::num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_hi [xc_pkg::num_pairs] = '{1, 2, 3, 2, 3, 3};

	logic intclk;
	logic rst;
	logic [xc_pkg::num_inputs-1:0] line_in;
	logic rx;
	logic tx;

	int errors;
	int checks;
	logic [7:0] frame [frame_len];
	logic [15:0] exp_words [xc_pkg::num_words];

	xc_top u_dut (
		.intclk (intclk),
		.rst (rst),
		.line_in (line_in),
		.rx (rx),
		.tx (tx)
	);

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;
	end

	function automatic logic [15:0] sat16(input int value);
		if (value > 65535)
			return 16'hffff;
		if (value < 0)
			return 16'h0000;
		return 16'(value);
	endfunction

	function automatic string word_name(input int i);
		if (i < auto_base)
			return $sformatf("total[%0d]", i);
		if (i < cross_base)
			return $sformatf("auto[%0d] lag %0d", (i - auto_base) / xc_pkg::max_lag,
				(i - auto_base) % xc_pkg::max_lag + 1);
		return $sformatf("cross[%0d-%0d]", pair_lo[i - cross_base], pair_hi[i - cross_base]);
	endfunction

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	// one 8N1 byte on rx, lsb first.
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge intclk);
			rx = bits[i];
			repeat (bit_cycles - 1) @(negedge intclk);
		end
	endtask

	task automatic set_lines(input logic [xc_pkg::num_inputs-1:0] value);
		@(negedge intclk);
		line_in = value;
		// let the levels pass the input synchronizer.
		repeat (4) @(negedge intclk);
	endtask

	task automatic receive_byte(input int timeout, output logic [7:0] value, output bit ok);
		int waited;
		waited = 0;
		ok = 1'b0;
		value = '0;
		while (tx !== 1'b0 && waited < timeout) begin
			@(negedge intclk);
			waited++;
		end
		if (tx !== 1'b0) begin
			errors++;
			$display("timeout at %0t: no start bit on tx within %0d cycles", $time, timeout);
			return;
		end
		repeat (bit_cycles / 2) @(negedge intclk);
		if (tx !== 1'b0) begin
			errors++;
			$display("error at %0t: start bit on tx ended early", $time);
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (bit_cycles) @(negedge intclk);
			value[i] = tx;
		end
		repeat (bit_cycles) @(negedge intclk);
		if (tx !== 1'b1) begin
			errors++;
			$display("error at %0t: stop bit on tx was low", $time);
			return;
		end
		ok = 1'b1;
	endtask

	// bytes inside a frame follow each other within a few bit times.
	task automatic receive_frame(input int first_timeout, output bit ok);
		bit got;
		ok = 1'b0;
		for (int i = 0; i < frame_len; i++) begin
			receive_byte((i == 0) ? first_timeout : 200, frame[i], got);
			if (!got)
				return;
		end
		ok = 1'b1;
	endtask

	task automatic wait_tx_quiet(input int quiet, input int timeout);
		int idle;
		int waited;
		idle = 0;
		waited = 0;
		while (idle < quiet && waited < timeout) begin
			@(negedge intclk);
			waited++;
			idle = (tx === 1'b1) ? idle + 1 : 0;
		end
		if (idle < quiet) begin
			errors++;
			$display("timeout at %0t: tx did not go idle", $time);
		end
	endtask

	task automatic expect_no_frame(input int cycles);
		checks++;
		for (int i = 0; i < cycles; i++) begin
			@(negedge intclk);
			if (tx !== 1'b1) begin
				errors++;
				$display("error at %0t: a frame started on tx while none was due", $time);
				return;
			end
		end
	endtask

	// static levels: a high line scores every sample, lag k misses k samples
	// in the first window after start because the history starts cleared.
	task automatic build_expected(input logic [xc_pkg::num_inputs-1:0] lines, input int len,
		input bit first_window);
		int lag_loss;
		for (int i = 0; i < xc_pkg::num_inputs; i++) begin
			exp_words[i] = lines[i] ? sat16(len) : 16'h0000;
			for (int k = 1; k <= xc_pkg::max_lag; k++) begin
				lag_loss = first_window ? k : 0;
				exp_words[auto_base + i * xc_pkg::max_lag + k - 1] =
					lines[i] ? sat16(len - lag_loss) : 16'h0000;
			end
		end
		for (int p = 0; p < xc_pkg::num_pairs; p++)
			exp_words[cross_base + p] =
				(lines[pair_lo[p]] && lines[pair_hi[p]]) ? sat16(len) : 16'h0000;
	endtask

	task automatic check_frame(input bit check_seq, input logic [7:0] exp_seq);
		compare_value("frame header", {8'h00, frame[0]}, 16'h00a5);
		if (check_seq)
			compare_value("frame seq", {8'h00, frame[1]}, {8'h00, exp_seq});
		for (int i = 0; i < xc_pkg::num_words; i++)
			compare_value(word_name(i), {frame[2 + 2 * i], frame[3 + 2 * i]}, exp_words[i]);
	endtask

	task automatic stop_and_drain();
		send_byte(xc_pkg::cmd_stop);
		wait_tx_quiet(200, 20000);
	endtask

	task automatic defaults_after_reset();
		bit ok;
		expect_no_frame(600);
		set_lines(4'b1111);
		send_byte(xc_pkg::cmd_start);
		receive_frame(2000, ok);
		if (!ok)
			return;
		build_expected(4'b1111, 16, 1'b1);
		check_frame(1'b1, 8'd0);
	endtask

	task automatic mixed_line_levels();
		bit ok;
		logic [7:0] first_seq;
		stop_and_drain();
		set_lines(4'b0101);
		send_byte(xc_pkg::cmd_start);
		receive_frame(2000, ok);
		if (!ok)
			return;
		build_expected(4'b0101, 16, 1'b1);
		check_frame(1'b0, 8'd0);
		first_seq = frame[1];
		receive_frame(2000, ok);
		if (!ok)
			return;
		build_expected(4'b0101, 16, 1'b0);
		check_frame(1'b1, first_seq + 8'd1);
	endtask

	task automatic command_handling();
		bit ok;
		logic [7:0] first_seq;
		stop_and_drain();
		// stray bytes around the set commands must change nothing.
		send_byte(8'h55);
		send_byte(xc_pkg::cmd_set_div);
		send_byte(8'd2);
		send_byte(8'h7e);
		send_byte(8'h00);
		send_byte(xc_pkg::cmd_set_len);
		send_byte(8'h00);
		send_byte(8'd40);
		send_byte(8'hc3);
		set_lines(4'b1011);
		send_byte(xc_pkg::cmd_start);
		// at divider 2 the first 40-sample window closes about 80 cycles after start.
		receive_frame(40 * 2 + 40, ok);
		if (!ok)
			return;
		build_expected(4'b1011, 40, 1'b1);
		check_frame(1'b0, 8'd0);
		first_seq = frame[1];
		receive_frame(3000, ok);
		if (!ok)
			return;
		build_expected(4'b1011, 40, 1'b0);
		check_frame(1'b1, first_seq + 8'd1);
	endtask

	task automatic counter_saturation();
		bit ok;
		stop_and_drain();
		send_byte(xc_pkg::cmd_set_div);
		send_byte(8'd1);
		send_byte(xc_pkg::cmd_set_len);
		send_byte(8'hff);
		send_byte(8'hff);
		set_lines(4'b1111);
		send_byte(xc_pkg::cmd_start);
		receive_frame(80000, ok);
		if (!ok)
			return;
		build_expected(4'b1111, 65535, 1'b1);
		check_frame(1'b0, 8'd0);
	endtask

	task automatic sequence_and_stop();
		bit ok;
		logic [7:0] first_seq;
		stop_and_drain();
		send_byte(xc_pkg::cmd_set_len);
		send_byte(8'h00);
		send_byte(8'd16);
		set_lines(4'b0110);
		send_byte(xc_pkg::cmd_start);
		receive_frame(2000, ok);
		if (!ok)
			return;
		build_expected(4'b0110, 16, 1'b1);
		check_frame(1'b0, 8'd0);
		first_seq = frame[1];
		for (int n = 1; n <= 2; n++) begin
			receive_frame(2000, ok);
			if (!ok)
				return;
			build_expected(4'b0110, 16, 1'b0);
			check_frame(1'b1, first_seq + 8'(n));
		end
		stop_and_drain();
		expect_no_frame(2000);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		rst = 1'b1;
		line_in = '0;
		rx = 1'b1;
		repeat (16) @(posedge intclk);
		@(negedge intclk);
		rst = 1'b0;
		defaults_after_reset();
		mixed_line_levels();
		command_handling();
		counter_saturation();
		sequence_and_stop();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: xc_top.f
xc_pkg.sv
xc_counts_if.sv
xc_tick_gen.sv
xc_correlator.sv
xc_uart_rx.sv
xc_uart_tx.sv
xc_cmd_parser.sv
xc_frame_sender.sv
xc_top.sv
tb_xc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_xc_top -f xc_top.f -Mdir obj_dir -o tb_xc_top \
	&& ./obj_dir/tb_xc_top > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
